/* rtl/sh_core_cfg.svh */
`ifndef SH_CORE_CFG_SVH
`define SH_CORE_CFG_SVH

// General register count
`define SH_REG_COUNT 16

// PC after reset
`define SH_RESET_PC 32'h0000_0000

// NOP encoding, also used for pipeline bubbles
`define SH_NOP_CODE 16'h0009

// Halfword instruction step
`define SH_INSTR_STEP 32'd2

`endif

/* rtl/sh_core_pkg.sv */
package sh_core_pkg;

	// Data and address words
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// SH instructions are one halfword
	typedef logic [15:0] instr_t;

	typedef logic [3:0]  reg_idx_t;

	// **************************************
	// ALU operations
	// **************************************
	typedef enum logic [2:0] {
		ALU_PASS_B = 3'd0,
		ALU_ADD    = 3'd1,
		ALU_SUB    = 3'd2,
		ALU_AND    = 3'd3,
		ALU_OR     = 3'd4,
		ALU_XOR    = 3'd5,
		ALU_CMPEQ  = 3'd6,
		ALU_MOVT   = 3'd7
	} alu_op_e;

	// Longword accesses only
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_e;

endpackage

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`include "sh_core_cfg.svh"

module reg_file import sh_core_pkg::*; (
	input  logic     CLK,
	input  logic     RST_N,
	input  reg_idx_t ra_idx,
	output word_t    ra_data,
	input  reg_idx_t rb_idx,
	output word_t    rb_data,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	input  logic     wr_en
);

	word_t regs [`SH_REG_COUNT];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < `SH_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write-through on a same cycle write
	assign ra_data = (wr_en && wr_idx == ra_idx) ? wr_data : regs[ra_idx];
	assign rb_data = (wr_en && wr_idx == rb_idx) ? wr_data : regs[rb_idx];

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps
`include "sh_core_cfg.svh"

module fetch_stage import sh_core_pkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	output logic   fetch_req,
	output addr_t  fetch_addr,
	input  logic   fetch_done,
	input  word_t  bus_rdata,
	input  logic   bus_stall,
	input  logic   id_hold,
	output instr_t id_instr
);

	addr_t  pc;
	instr_t save_half;
	logic   fetch_en;
	logic   have_instr;
	logic   advance;

	// Odd halfword comes from the saved word, even one needs the bus
	assign have_instr = pc[1] | fetch_done;
	assign advance    = have_instr & ~bus_stall & ~id_hold;

	assign fetch_req  = fetch_en & ~pc[1];
	assign fetch_addr = {pc[31:2], 2'b00};

	// No bus request while in reset
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc <= `SH_RESET_PC;
		end else if (advance) begin
			pc <= pc + `SH_INSTR_STEP;
		end
	end

	always_ff @(posedge CLK) begin
		if (advance && !pc[1]) begin
			save_half <= bus_rdata[15:0];
		end
	end

	// **************************************
	// IF/ID register
	// **************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			id_instr <= `SH_NOP_CODE;
		end else if (!bus_stall && !id_hold) begin
			if (pc[1]) begin
				id_instr <= save_half;
			end else if (fetch_done) begin
				// Big endian, upper half is the lower address
				id_instr <= bus_rdata[31:16];
			end else begin
				id_instr <= `SH_NOP_CODE;
			end
		end
	end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`include "sh_core_cfg.svh"

module decode_stage import sh_core_pkg::*; (
	input  logic     CLK,
	input  logic     RST_N,
	input  instr_t   id_instr,
	input  logic     bus_stall,
	output reg_idx_t ra_idx,
	output reg_idx_t rb_idx,
	input  word_t    ra_data,
	input  word_t    rb_data,
	input  reg_idx_t wb_dest,
	input  word_t    wb_data,
	input  logic     wb_we,
	input  logic     ex_is_load,
	input  reg_idx_t ex_dest,
	output logic     id_hold,
	output word_t    ex_a,
	output word_t    ex_b,
	output reg_idx_t ex_src_a,
	output reg_idx_t ex_src_b,
	output reg_idx_t ex_dst,
	output logic     ex_we,
	output logic     ex_imm,
	output alu_op_e  ex_alu_op,
	output mem_op_e  ex_mem_op
);

	reg_idx_t rn;
	word_t    imm_val;
	logic     use_a;
	logic     use_b;
	logic     dec_imm;
	logic     dec_we;
	alu_op_e  dec_alu;
	mem_op_e  dec_mem;

	assign rn      = id_instr[11:8];
	assign rb_idx  = id_instr[7:4];
	assign imm_val = {{24{id_instr[7]}}, id_instr[7:0]};

	// **************************************
	// Decoder
	// **************************************
	always_comb begin
		{use_a, use_b, dec_imm, dec_we} = 4'b0000;
		dec_alu = ALU_PASS_B;
		dec_mem = MEM_NONE;
		ra_idx  = rn;
		casez (id_instr)
			`SH_NOP_CODE: ;
			// MOV #imm,Rn
			16'b1110_????_????_????: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b0011;
			end
			// MOV Rm,Rn
			16'b0110_????_????_0011: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b0101;
			end
			16'b0011_????_????_1100: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1101;
				dec_alu = ALU_ADD;
			end
			// ADD #imm,Rn
			16'b0111_????_????_????: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1011;
				dec_alu = ALU_ADD;
			end
			16'b0011_????_????_1000: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1101;
				dec_alu = ALU_SUB;
			end
			16'b0010_????_????_1001: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1101;
				dec_alu = ALU_AND;
			end
			16'b0010_????_????_1010: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1101;
				dec_alu = ALU_XOR;
			end
			16'b0010_????_????_1011: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1101;
				dec_alu = ALU_OR;
			end
			// CMP/EQ only touches T
			16'b0011_????_????_0000: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1100;
				dec_alu = ALU_CMPEQ;
			end
			16'b0000_????_0010_1001: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b0001;
				dec_alu = ALU_MOVT;
			end
			// MOV.L @Rm,Rn with the address in Rm
			16'b0110_????_????_0010: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1001;
				ra_idx  = id_instr[7:4];
				dec_mem = MEM_LOAD;
			end
			// MOV.L Rm,@Rn
			16'b0010_????_????_0010: begin
				{use_a, use_b, dec_imm, dec_we} = 4'b1100;
				dec_mem = MEM_STORE;
			end
			default: ;
		endcase
	end

	// Load in EX feeding this instruction costs one bubble
	assign id_hold = ex_is_load &
	                 ((use_a & (ex_dest == ra_idx)) | (use_b & (ex_dest == rb_idx)));

	// **************************************
	// ID/EX register
	// **************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex_src_a  <= '0;
			ex_src_b  <= '0;
			ex_dst    <= '0;
			ex_we     <= 1'b0;
			ex_imm    <= 1'b0;
			ex_alu_op <= ALU_PASS_B;
			ex_mem_op <= MEM_NONE;
		end else if (!bus_stall) begin
			ex_src_a  <= ra_idx;
			ex_src_b  <= rb_idx;
			ex_dst    <= rn;
			ex_imm    <= dec_imm;
			ex_we     <= dec_we & ~id_hold;
			ex_alu_op <= id_hold ? ALU_PASS_B : dec_alu;
			ex_mem_op <= id_hold ? MEM_NONE : dec_mem;
		end
	end

	always_ff @(posedge CLK) begin
		if (!bus_stall) begin
			ex_a <= ra_data;
			ex_b <= dec_imm ? imm_val : rb_data;
		end
	end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import sh_core_pkg::*; (
	input  logic     CLK,
	input  logic     RST_N,
	input  word_t    ex_a,
	input  word_t    ex_b,
	input  reg_idx_t ex_src_a,
	input  reg_idx_t ex_src_b,
	input  reg_idx_t ex_dst,
	input  logic     ex_we,
	input  logic     ex_imm,
	input  alu_op_e  ex_alu_op,
	input  mem_op_e  ex_mem_op,
	input  logic     bus_stall,
	output logic     ex_is_load,
	output reg_idx_t ex_dest,
	input  reg_idx_t wb_dest,
	input  word_t    wb_data,
	input  logic     wb_we,
	output word_t    ma_result,
	output reg_idx_t ma_dest,
	output logic     ma_we,
	output mem_op_e  ma_mem_op,
	output addr_t    ma_addr,
	output word_t    ma_wdata
);

	logic  ma_fwd;
	logic  eq;
	logic  t_bit;
	word_t op_a;
	word_t op_b;
	word_t alu_res;

	assign ex_is_load = (ex_mem_op == MEM_LOAD);
	assign ex_dest    = ex_dst;

	// **************************************
	// Bypass
	// **************************************
	// Load data is not back yet while the load sits in MA
	assign ma_fwd = ma_we & (ma_mem_op != MEM_LOAD);

	assign op_a = (ma_fwd && ma_dest == ex_src_a) ? ma_result :
	              (wb_we && wb_dest == ex_src_a) ? wb_data : ex_a;

	assign op_b = ex_imm ? ex_b :
	              (ma_fwd && ma_dest == ex_src_b) ? ma_result :
	              (wb_we && wb_dest == ex_src_b) ? wb_data : ex_b;

	// **************************************
	// ALU
	// **************************************
	assign eq = (op_a == op_b);

	always_comb begin
		case (ex_alu_op)
			ALU_ADD:   alu_res = op_a + op_b;
			ALU_SUB:   alu_res = op_a - op_b;
			ALU_AND:   alu_res = op_a & op_b;
			ALU_OR:    alu_res = op_a | op_b;
			ALU_XOR:   alu_res = op_a ^ op_b;
			ALU_CMPEQ: alu_res = {31'd0, eq};
			ALU_MOVT:  alu_res = {31'd0, t_bit};
			default:   alu_res = op_b;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			t_bit <= 1'b0;
		end else if (!bus_stall && ex_alu_op == ALU_CMPEQ) begin
			t_bit <= eq;
		end
	end

	// **************************************
	// EX/MA register
	// **************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ma_dest   <= '0;
			ma_we     <= 1'b0;
			ma_mem_op <= MEM_NONE;
		end else if (!bus_stall) begin
			ma_dest   <= ex_dst;
			ma_we     <= ex_we;
			ma_mem_op <= ex_mem_op;
		end
	end

	// Address register on A, store data on B
	always_ff @(posedge CLK) begin
		if (!bus_stall) begin
			ma_result <= alu_res;
			ma_addr   <= op_a;
			ma_wdata  <= op_b;
		end
	end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import sh_core_pkg::*; (
	input  logic     CLK,
	input  logic     RST_N,
	input  word_t    ma_result,
	input  reg_idx_t ma_dest,
	input  logic     ma_we,
	input  mem_op_e  ma_mem_op,
	input  addr_t    ma_addr,
	input  word_t    ma_wdata,
	input  logic     fetch_req,
	input  addr_t    fetch_addr,
	output logic     fetch_done,
	output logic     bus_stall,
	output reg_idx_t wb_dest,
	output word_t    wb_data,
	output logic     wb_we,
	output addr_t    BUS_A,
	input  word_t    BUS_DI,
	output word_t    BUS_DO,
	output logic     BUS_WR,
	output logic     BUS_REQ,
	input  logic     BUS_WAIT
);

	logic ma_access;
	logic wb_we_q;

	// **************************************
	// Bus arbitration
	// **************************************
	// MA wins the bus, fetch retries next cycle
	assign ma_access  = (ma_mem_op != MEM_NONE);
	assign bus_stall  = ma_access & BUS_WAIT;
	assign fetch_done = fetch_req & ~ma_access & ~BUS_WAIT;

	assign BUS_REQ = ma_access | fetch_req;
	assign BUS_WR  = (ma_mem_op == MEM_STORE);
	assign BUS_A   = ma_access ? ma_addr : fetch_addr;
	assign BUS_DO  = ma_wdata;

	// **************************************
	// MA/WB register
	// **************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wb_dest <= '0;
			wb_we_q <= 1'b0;
		end else if (!bus_stall) begin
			wb_dest <= ma_dest;
			wb_we_q <= ma_we;
		end
	end

	always_ff @(posedge CLK) begin
		if (!bus_stall) begin
			wb_data <= (ma_mem_op == MEM_LOAD) ? BUS_DI : ma_result;
		end
	end

	// WB holds during a stall, write once when it clears
	assign wb_we = wb_we_q & ~bus_stall;

endmodule

/* rtl/sh_core_top.sv */
`timescale 1ns/1ps

module sh_core_top import sh_core_pkg::*; (
	input  logic  CLK,
	input  logic  RST_N,
	output addr_t BUS_A,
	input  word_t BUS_DI,
	output word_t BUS_DO,
	output logic  BUS_WR,
	output logic  BUS_REQ,
	input  logic  BUS_WAIT
);

	// Fetch path and stall controls
	logic     fetch_req;
	addr_t    fetch_addr;
	logic     fetch_done;
	logic     bus_stall;
	logic     id_hold;
	instr_t   id_instr;

	// Register file reads
	reg_idx_t ra_idx;
	reg_idx_t rb_idx;
	word_t    ra_data;
	word_t    rb_data;

	// ID/EX
	word_t    ex_a;
	word_t    ex_b;
	reg_idx_t ex_src_a;
	reg_idx_t ex_src_b;
	reg_idx_t ex_dst;
	logic     ex_we;
	logic     ex_imm;
	alu_op_e  ex_alu_op;
	mem_op_e  ex_mem_op;
	logic     ex_is_load;
	reg_idx_t ex_dest;

	// EX/MA
	word_t    ma_result;
	reg_idx_t ma_dest;
	logic     ma_we;
	mem_op_e  ma_mem_op;
	addr_t    ma_addr;
	word_t    ma_wdata;

	// WB
	reg_idx_t wb_dest;
	word_t    wb_data;
	logic     wb_we;

	fetch_stage u_fetch (.*, .bus_rdata(BUS_DI));

	decode_stage u_decode (.*);

	reg_file u_regs (.*, .wr_idx(wb_dest), .wr_data(wb_data), .wr_en(wb_we));

	execute_stage u_execute (.*);

	mem_stage u_mem (.*);

endmodule

/* sim/sh_core_tb.sv */
`timescale 1ns/1ps
`include "sh_core_cfg.svh"

module sh_core_tb import sh_core_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int MEM_WORDS    = 4096;
	// Halfwords in words 0 to 63
	localparam int PROG_LEN     = 128;
	// R15 points at words 16 to 31, so memory access starts once they are fetched
	localparam int MEM_START    = 64;
	localparam int TAIL_START   = 96;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + PROG_LEN * 4) * CLK_PERIOD;

	localparam addr_t DATA_LO = 32'd64;
	localparam addr_t DATA_HI = 32'd124;

	// Instruction kinds with the ALU kinds in one consecutive run
	localparam int K_NOP   = 0;
	localparam int K_MOVI  = 1;
	localparam int K_MOV   = 2;
	localparam int K_ADD   = 3;
	localparam int K_ADDI  = 4;
	localparam int K_SUB   = 5;
	localparam int K_AND   = 6;
	localparam int K_OR    = 7;
	localparam int K_XOR   = 8;
	localparam int K_CMPEQ = 9;
	localparam int K_MOVT  = 10;
	localparam int K_LOAD  = 11;
	localparam int K_STORE = 12;

	logic  CLK;
	logic  RST_N;
	addr_t BUS_A;
	word_t BUS_DI;
	word_t BUS_DO;
	logic  BUS_WR;
	logic  BUS_REQ;
	logic  BUS_WAIT;

	word_t    mem [MEM_WORDS];
	word_t    image [MEM_WORDS];
	word_t    model_mem [MEM_WORDS];
	int       prog_kind [PROG_LEN];
	reg_idx_t prog_n [PROG_LEN];
	reg_idx_t prog_m [PROG_LEN];
	logic [7:0] prog_imm [PROG_LEN];
	addr_t    exp_addr [$];
	word_t    exp_data [$];
	int       prog_pos;
	int       last_dst;
	int       n_exp;
	int       n_seen = 0;
	integer   seed = 32'h8b96bd73;

	sh_core_top dut_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.BUS_A    (BUS_A),
		.BUS_DI   (BUS_DI),
		.BUS_DO   (BUS_DO),
		.BUS_WR   (BUS_WR),
		.BUS_REQ  (BUS_REQ),
		.BUS_WAIT (BUS_WAIT)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	function automatic int rand_below(int n);
		rand_below = int'($unsigned($random(seed)) % n);
	endfunction

	// ****************************************
	// Program generation
	// ****************************************
	function automatic instr_t encode(int kind, reg_idx_t n, reg_idx_t m, logic [7:0] imm);
		case (kind)
			K_MOVI:  encode = {4'hE, n, imm};
			K_MOV:   encode = {4'h6, n, m, 4'h3};
			K_ADD:   encode = {4'h3, n, m, 4'hC};
			K_ADDI:  encode = {4'h7, n, imm};
			K_SUB:   encode = {4'h3, n, m, 4'h8};
			K_AND:   encode = {4'h2, n, m, 4'h9};
			K_XOR:   encode = {4'h2, n, m, 4'hA};
			K_OR:    encode = {4'h2, n, m, 4'hB};
			K_CMPEQ: encode = {4'h3, n, m, 4'h0};
			K_MOVT:  encode = {4'h0, n, 8'h29};
			K_LOAD:  encode = {4'h6, n, m, 4'h2};
			K_STORE: encode = {4'h2, n, m, 4'h2};
			default: encode = `SH_NOP_CODE;
		endcase
	endfunction

	task automatic emit_instr(int kind, int n, int m, int imm);
		instr_t code;
		int     w;
		prog_kind[prog_pos] = kind;
		prog_n[prog_pos]    = reg_idx_t'(n);
		prog_m[prog_pos]    = reg_idx_t'(m);
		prog_imm[prog_pos]  = 8'(imm);
		code = encode(kind, reg_idx_t'(n), reg_idx_t'(m), 8'(imm));
		w = prog_pos / 2;
		// Lower address is the upper half
		if (prog_pos % 2 == 0) begin
			image[w][31:16] = code;
		end else begin
			image[w][15:0] = code;
		end
		prog_pos++;
	endtask

	task automatic emit_random_alu();
		int kind;
		int n;
		int m;
		kind = K_MOVI + rand_below(10);
		n    = rand_below(15);
		// Half the sources come from the last result
		m    = (rand_below(2) == 0) ? last_dst : rand_below(16);
		if (kind == K_CMPEQ && rand_below(2) == 0) begin
			m = n;
		end
		emit_instr(kind, n, m, rand_below(256));
		if (kind != K_CMPEQ) begin
			last_dst = n;
		end
	endtask

	task automatic build_program();
		int n;
		for (int i = 0; i < MEM_WORDS; i++) begin
			image[i] = 32'(i) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
		end
		prog_pos = 0;
		last_dst = 0;
		emit_instr(K_MOVI, 15, 0, 64 + 4 * rand_below(16));
		for (int r = 0; r < 15; r++) begin
			emit_instr(K_MOVI, r, 0, rand_below(256));
		end
		// T from a known value
		emit_instr(K_CMPEQ, 0, 0, 0);
		while (prog_pos < MEM_START) begin
			emit_random_alu();
		end
		while (prog_pos < TAIL_START - 1) begin
			case (rand_below(4))
				0: emit_instr(K_STORE, 15, rand_below(15), 0);
				1: begin
					// Load followed at once by a use
					n = rand_below(15);
					emit_instr(K_LOAD, n, 15, 0);
					last_dst = rand_below(15);
					emit_instr(K_ADD, last_dst, n, 0);
				end
				default: emit_random_alu();
			endcase
		end
		while (prog_pos < TAIL_START) begin
			emit_instr(K_NOP, 0, 0, 0);
		end
		for (int r = 0; r < 15; r++) begin
			emit_instr(K_STORE, 15, r, 0);
		end
		emit_instr(K_MOVT, 0, 0, 0);
		emit_instr(K_STORE, 15, 0, 0);
		while (prog_pos < PROG_LEN) begin
			emit_instr(K_NOP, 0, 0, 0);
		end
	endtask

	// ****************************************
	// ISA model
	// ****************************************
	task automatic run_model();
		word_t r [16];
		logic  t;
		word_t imm;
		reg_idx_t n;
		reg_idx_t m;
		t = 1'b0;
		for (int i = 0; i < 16; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = image[i];
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			n   = prog_n[i];
			m   = prog_m[i];
			imm = {{24{prog_imm[i][7]}}, prog_imm[i]};
			case (prog_kind[i])
				K_MOVI:  r[n] = imm;
				K_MOV:   r[n] = r[m];
				K_ADD:   r[n] = r[n] + r[m];
				K_ADDI:  r[n] = r[n] + imm;
				K_SUB:   r[n] = r[n] - r[m];
				K_AND:   r[n] = r[n] & r[m];
				K_OR:    r[n] = r[n] | r[m];
				K_XOR:   r[n] = r[n] ^ r[m];
				K_CMPEQ: t = (r[n] == r[m]);
				K_MOVT:  r[n] = {31'd0, t};
				K_LOAD:  r[n] = model_mem[r[m][13:2]];
				K_STORE: begin
					model_mem[r[n][13:2]] = r[m];
					exp_addr.push_back(r[n]);
					exp_data.push_back(r[m]);
				end
				default: ;
			endcase
		end
		n_exp = exp_addr.size();
	endtask

	// ****************************************
	// Checks
	// ****************************************
	task automatic report_mismatch(string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_level(logic got, logic exp, string what);
		if (got !== exp) begin
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_pending(addr_t addr);
		if (exp_addr.size() == 0) begin
			report_mismatch($sformatf("BUS_WR high at %h with no store left", addr));
		end else if (addr !== exp_addr[0]) begin
			report_mismatch($sformatf("store pending at %h, expected %h", addr, exp_addr[0]));
		end
	endtask

	task automatic check_store(addr_t addr, word_t data);
		addr_t ea;
		word_t ed;
		if (exp_addr.size() == 0) begin
			report_mismatch($sformatf("store of %h to %h with none expected", data, addr));
		end else begin
			ea = exp_addr.pop_front();
			ed = exp_data.pop_front();
			if (addr < DATA_LO || addr > DATA_HI || addr[1:0] != 2'b00) begin
				report_mismatch($sformatf("store to %h outside the data area", addr));
			end else if (addr !== ea || data !== ed) begin
				report_mismatch($sformatf("store %0d wrote %h to %h, expected %h to %h",
					n_seen, data, addr, ed, ea));
			end
			n_seen++;
		end
	endtask

	// ****************************************
	// Bus memory model
	// ****************************************
	assign BUS_DI = mem[BUS_A[13:2]];

	always @(posedge CLK) begin
		BUS_WAIT <= (rand_below(4) == 0);
		if (!RST_N) begin
			check_level(BUS_REQ, 1'b0, "BUS_REQ in reset");
			check_level(BUS_WR, 1'b0, "BUS_WR in reset");
		end else if (BUS_WR) begin
			check_level(BUS_REQ, 1'b1, "BUS_REQ with BUS_WR");
			check_pending(BUS_A);
			if (!BUS_WAIT) begin
				check_store(BUS_A, BUS_DO);
				mem[BUS_A[13:2]] <= BUS_DO;
			end
		end
	end

	initial begin
		RST_N    <= 1'b0;
		BUS_WAIT <= 1'b0;
		build_program();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] <= image[i];
		end
		run_model();
		repeat (RESET_CYCLES) @(posedge CLK);
		RST_N <= 1'b1;
		wait (n_seen == n_exp);
		// Room for a stray store to show up
		repeat (4) @(posedge CLK);
		$display("No errors");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: %0d of %0d stores seen after %0d ns", n_seen, n_exp, TIMEOUT_NS);
		$display("Errors found");
		$fatal(1);
	end

endmodule

/* sh_core_top.f */
+incdir+rtl
rtl/sh_core_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/sh_core_top.sv
sim/sh_core_tb.sv

/* Makefile */
LOG := sim.log

sim:
	verilator --binary --timing -Wno-fatal --top-module sh_core_tb -f sh_core_top.f -o sh_core_sim
	./obj_dir/sh_core_sim | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
